// File: tb.f
hw/arcade_io_pkg.sv
hw/arcade_io_ifs.sv
hw/host_download.sv
hw/rom_loader.sv
hw/player_port.sv
hw/cabinet_inputs.sv
hw/arcade_io_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR VFLAGS TOP FILELIST OBJ_DIR"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_top.sv
// The host leaves two idle cycles after each ROM byte and only then polls ioctl_wait
`timescale 1ns/1ns

module tb_top import arcade_io_pkg::*; ();

	localparam int JOY_CYCLES   = 600;
	// Menu pause mixed in for the last part of the joystick phase
	localparam int OSD_START    = 400;
	localparam int SET_CYCLES   = 300;
	localparam int ROM_BYTES    = 256;
	localparam int DRAIN_CYCLES = 10;
	// A byte pair takes at most 12 cycles with a 3 cycle ack delay
	localparam int TIMEOUT_CYCLES = JOY_CYCLES + SET_CYCLES + ROM_BYTES * 8 + 1000;

	logic      MS_CLK;
	logic      arst_n;
	joy_word_t joystick_0;
	joy_word_t joystick_1;
	logic      osd_status;
	logic      pause_in_osd;
	logic      ioctl_wr;
	dl_index_t ioctl_index;
	dl_addr_t  ioctl_addr;
	byte_t     ioctl_dout;
	logic      ioctl_wait;
	byte_t     player1;
	byte_t     player2;
	byte_t     dsw1;
	byte_t     dsw2;
	byte_t     game;
	logic      service;
	logic      pause_cpu;
	logic      mem_cyc;
	logic      mem_stb;
	mem_adr_t  mem_adr;
	rom_word_t mem_dat;
	logic      mem_ack = 1'b0;
	logic      report_req;
	logic      report_done;
	int        err_total;

	logic [15:0] stim_lfsr = 16'd26;
	logic [15:0] ack_lfsr  = 16'd26;
	logic [15:0] r;
	logic [15:0] d;
	dl_addr_t    rom_base;
	logic        ack_busy;
	logic [1:0]  ack_cnt;
	int          cycles = 0;

	tb_clock u_clock (.*);
	arcade_io_top uut (.*);
	tb_checker u_checker (.*, .exp_words(ROM_BYTES / 2));

	// Galois step, taps x^16 x^14 x^13 x^11, returns {bit out, next state}
	function automatic logic [16:0] lfsr_step(input logic [15:0] s);
		logic [15:0] nxt;
		nxt = s >> 1;
		if (s[0]) begin
			nxt = nxt ^ 16'hB400;
		end
		return {s[0], nxt};
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] acc;
		logic [16:0] st;
		acc = '0;
		for (int i = 0; i < n; i++) begin
			st        = lfsr_step(stim_lfsr);
			acc       = {acc[14:0], st[16]};
			stim_lfsr = st[15:0];
		end
		return acc;
	endfunction

	// Responder has its own stream
	function automatic logic [1:0] ack_delay();
		logic [16:0] st;
		logic [1:0]  acc;
		acc = '0;
		for (int i = 0; i < 2; i++) begin
			st       = lfsr_step(ack_lfsr);
			acc      = {acc[0], st[16]};
			ack_lfsr = st[15:0];
		end
		return acc;
	endfunction

	// One ROM byte, then hold off while the loader is busy
	task automatic write_rom_byte(input dl_addr_t a, input byte_t v);
		ioctl_wr    <= 1'b1;
		ioctl_index <= DL_INDEX_ROM;
		ioctl_addr  <= a;
		ioctl_dout  <= v;
		@(posedge MS_CLK);
		ioctl_wr <= 1'b0;
		repeat (2) @(posedge MS_CLK);
		while (ioctl_wait) begin
			@(posedge MS_CLK);
		end
	endtask

	////////////////////////////////////////////////////
	// Wishbone memory, ack after 0 to 3 extra cycles
	////////////////////////////////////////////////////
	always @(posedge MS_CLK) begin
		if (!arst_n) begin
			mem_ack  <= 1'b0;
			ack_busy <= 1'b0;
			ack_cnt  <= 2'd0;
		end else if (mem_ack) begin
			mem_ack  <= 1'b0;
			ack_busy <= 1'b0;
		end else if (mem_cyc && mem_stb) begin
			if (!ack_busy) begin
				ack_busy <= 1'b1;
				ack_cnt  <= ack_delay();
			end else if (ack_cnt == 2'd0) begin
				mem_ack <= 1'b1;
			end else begin
				ack_cnt <= ack_cnt - 2'd1;
			end
		end
	end

	always @(posedge MS_CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout, run stopped after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////
	initial begin
		joystick_0   <= '0;
		joystick_1   <= '0;
		osd_status   <= 1'b0;
		pause_in_osd <= 1'b0;
		ioctl_wr     <= 1'b0;
		ioctl_index  <= '0;
		ioctl_addr   <= '0;
		ioctl_dout   <= '0;
		report_req   <= 1'b0;
		@(posedge arst_n);
		@(posedge MS_CLK);

		// Random joystick words, pause bits included
		for (int i = 0; i < JOY_CYCLES; i++) begin
			r = rand_bits(16);
			joystick_0 <= r;
			r = rand_bits(16);
			joystick_1 <= r;
			if (i >= OSD_START) begin
				r = rand_bits(2);
				osd_status   <= r[0];
				pause_in_osd <= r[1];
			end
			@(posedge MS_CLK);
		end
		joystick_0   <= '0;
		joystick_1   <= '0;
		osd_status   <= 1'b0;
		pause_in_osd <= 1'b0;

		// Settings writes, index 0 kept out of this phase
		for (int i = 0; i < SET_CYCLES; i++) begin
			r = rand_bits(16);
			d = rand_bits(8);
			ioctl_wr <= r[0];
			case (r[2:1])
				2'd1: ioctl_index <= DL_INDEX_GAME;
				2'd2: ioctl_index <= (r[10:3] == DL_INDEX_ROM) ? 8'd2 : r[10:3];
				default: ioctl_index <= DL_INDEX_DIP;
			endcase
			ioctl_addr <= dl_addr_t'(r[13:12]) | (r[11] ? 25'h100 : 25'h0);
			ioctl_dout <= d[7:0];
			@(posedge MS_CLK);
		end
		ioctl_wr <= 1'b0;
		repeat (2) @(posedge MS_CLK);

		// ROM bytes at consecutive addresses from an even base
		r = rand_bits(16);
		rom_base = dl_addr_t'({r, 1'b0});
		for (int i = 0; i < ROM_BYTES; i++) begin
			d = rand_bits(8);
			write_rom_byte(rom_base + dl_addr_t'(i), d[7:0]);
		end

		repeat (DRAIN_CYCLES) @(posedge MS_CLK);
		report_req <= 1'b1;
		wait (report_done);
		// Error totals settle before the falling edge
		@(negedge MS_CLK);
		if (err_total == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: sim/tb_checker.sv
// Samples on the rising edge so each compare sees values settled one cycle earlier
`timescale 1ns/1ns

module tb_checker import arcade_io_pkg::*; (
	input  logic      MS_CLK,
	input  logic      arst_n,
	input  joy_word_t joystick_0,
	input  joy_word_t joystick_1,
	input  logic      osd_status,
	input  logic      pause_in_osd,
	input  logic      ioctl_wr,
	input  dl_index_t ioctl_index,
	input  dl_addr_t  ioctl_addr,
	input  byte_t     ioctl_dout,
	input  logic      ioctl_wait,
	input  byte_t     player1,
	input  byte_t     player2,
	input  byte_t     dsw1,
	input  byte_t     dsw2,
	input  byte_t     game,
	input  logic      service,
	input  logic      pause_cpu,
	input  logic      mem_cyc,
	input  logic      mem_stb,
	input  mem_adr_t  mem_adr,
	input  rom_word_t mem_dat,
	input  logic      mem_ack,
	input  int        exp_words,
	input  logic      report_req,
	output int        err_total,
	output logic      report_done
);

	int        value_errs = 0;
	int        proto_errs = 0;
	int        words_seen = 0;
	logic      done_q     = 1'b0;
	// DUT outputs are undefined before the first reset edge
	logic      reset_seen = 1'b0;
	// Joystick history, d1 one edge back and d2 two edges back
	joy_word_t j0_d1 = '0;
	joy_word_t j0_d2 = '0;
	joy_word_t j1_d1 = '0;
	joy_word_t j1_d2 = '0;
	logic      service_exp;
	// Pause model
	logic      pause0_d1 = 1'b0;
	logic      pause1_d1 = 1'b0;
	logic      rise_d1   = 1'b0;
	logic      rise_d2   = 1'b0;
	logic      rise_d3   = 1'b0;
	logic      latch_exp = 1'b0;
	logic      menu_d1   = 1'b0;
	logic      rise_now;
	// Settings and ROM word model
	byte_t     dsw1_exp = '0;
	byte_t     dsw2_exp = '0;
	byte_t     game_exp = '0;
	byte_t     lo_exp;
	logic      lo_valid = 1'b0;
	mem_adr_t  exp_adr_q[$];
	rom_word_t exp_dat_q[$];

	assign err_total   = value_errs + proto_errs;
	assign report_done = done_q;

	task automatic check_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			value_errs++;
			$display("FAIL %s expected 0x%0h got 0x%0h at %0t", name, exp_v, act_v, $time);
		end
	endtask

	task automatic report_error(input string msg);
		proto_errs++;
		$display("ERROR %s at %0t", msg, $time);
	endtask

	// Cabinet byte 1, starts cross with the other side's alt start
	function automatic byte_t player1_byte(input joy_word_t j0, input joy_word_t j1);
		return {~j1[JOY_START] & ~j0[JOY_ALT_START], ~j0[JOY_START] & ~j1[JOY_ALT_START],
			~j0[JOY_SW2], ~j0[JOY_SW1], ~j0[JOY_DOWN], ~j0[JOY_UP], ~j0[JOY_LEFT],
			~j0[JOY_RIGHT]};
	endfunction

	// Cabinet byte 2, both coins on top
	function automatic byte_t player2_byte(input joy_word_t j0, input joy_word_t j1);
		return {~j1[JOY_COIN], ~j0[JOY_COIN], ~j1[JOY_SW2], ~j1[JOY_SW1], ~j1[JOY_DOWN],
			~j1[JOY_UP], ~j1[JOY_LEFT], ~j1[JOY_RIGHT]};
	endfunction

	////////////////////////////////////////////////////
	// Per-cycle compare and model update
	////////////////////////////////////////////////////
	always @(posedge MS_CLK) begin
		// Latch catches rises three edges back, menu term one edge back
		latch_exp   = latch_exp ^ rise_d3;
		service_exp = ~j0_d2[JOY_SERVICE] & ~j1_d2[JOY_SERVICE];
		if (reset_seen) begin
			// Outputs set last cycle reflect joystick words from two edges back
			check_value("player1", 32'(player1_byte(j0_d2, j1_d2)), 32'(player1));
			check_value("player2", 32'(player2_byte(j0_d2, j1_d2)), 32'(player2));
			check_value("service", 32'(service_exp), 32'(service));
			check_value("pause_cpu", 32'(latch_exp | menu_d1), 32'(pause_cpu));
			check_value("dsw1", 32'(dsw1_exp), 32'(dsw1));
			check_value("dsw2", 32'(dsw2_exp), 32'(dsw2));
			check_value("game", 32'(game_exp), 32'(game));
			if (!arst_n) begin
				check_value("mem_cyc", 32'(1'b0), 32'(mem_cyc));
				check_value("mem_stb", 32'(1'b0), 32'(mem_stb));
				check_value("ioctl_wait", 32'(1'b0), 32'(ioctl_wait));
			end
		end

		// Bus protocol and word order
		if (mem_ack && !mem_cyc) begin
			report_error("mem_ack came with no open memory cycle");
		end
		if (mem_stb && !mem_cyc) begin
			report_error("mem_stb high without mem_cyc");
		end
		if (ioctl_wr && ioctl_wait) begin
			report_error("host wrote while ioctl_wait was high");
		end
		if (mem_cyc && mem_stb && mem_ack) begin
			words_seen++;
			if (exp_adr_q.size() == 0) begin
				report_error("memory cycle with no word expected");
			end else begin
				check_value("mem_adr", 32'(exp_adr_q.pop_front()), 32'(mem_adr));
				check_value("mem_dat", 32'(exp_dat_q.pop_front()), 32'(mem_dat));
			end
		end

		rise_now = (joystick_0[JOY_PAUSE] & ~pause0_d1) | (joystick_1[JOY_PAUSE] & ~pause1_d1);
		if (!arst_n) begin
			{j0_d1, j0_d2, j1_d1, j1_d2} = '0;
			{pause0_d1, pause1_d1, rise_d1, rise_d2, rise_d3} = '0;
			{latch_exp, menu_d1, lo_valid} = '0;
			{dsw1_exp, dsw2_exp, game_exp} = '0;
			reset_seen = 1'b1;
		end else begin
			j0_d2     = j0_d1;
			j0_d1     = joystick_0;
			j1_d2     = j1_d1;
			j1_d1     = joystick_1;
			rise_d3   = rise_d2;
			rise_d2   = rise_d1;
			rise_d1   = rise_now;
			pause0_d1 = joystick_0[JOY_PAUSE];
			pause1_d1 = joystick_1[JOY_PAUSE];
			menu_d1   = osd_status & pause_in_osd;
			// Settings decode, banks 0 and 1 and game at address 0
			if (ioctl_wr && ioctl_index == DL_INDEX_DIP && ioctl_addr == 25'd0) begin
				dsw1_exp = ioctl_dout;
			end
			if (ioctl_wr && ioctl_index == DL_INDEX_DIP && ioctl_addr == 25'd1) begin
				dsw2_exp = ioctl_dout;
			end
			if (ioctl_wr && ioctl_index == DL_INDEX_GAME && ioctl_addr == 25'd0) begin
				game_exp = ioctl_dout;
			end
			// Even byte waits for its odd partner
			if (ioctl_wr && ioctl_index == DL_INDEX_ROM) begin
				if (!ioctl_addr[0]) begin
					lo_exp   = ioctl_dout;
					lo_valid = 1'b1;
				end else if (lo_valid) begin
					exp_adr_q.push_back(ioctl_addr[DL_ADDR_W-1:1]);
					exp_dat_q.push_back({ioctl_dout, lo_exp});
					lo_valid = 1'b0;
				end
			end
		end

		// End of run summary
		if (report_req && !done_q) begin
			if (exp_adr_q.size() != 0) begin
				report_error("memory words still expected at end of run");
			end
			if (words_seen != exp_words) begin
				report_error($sformatf("saw %0d memory cycles instead of %0d",
					words_seen, exp_words));
			end
			$display("tb_checker: %0d value errors, %0d protocol errors, %0d memory words",
				value_errs, proto_errs, words_seen);
			done_q = 1'b1;
		end
	end

endmodule

// File: sim/tb_clock.sv
// MS_CLK runs at 40 ns and arst_n is released on a falling edge after four rising edges
`timescale 1ns/1ns

module tb_clock (
	output logic MS_CLK,
	output logic arst_n
);

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 4;

	initial begin
		MS_CLK = 1'b0;
		forever #(HALF_PERIOD) MS_CLK = ~MS_CLK;
	end

	// Release away from the rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge MS_CLK);
		@(negedge MS_CLK);
		arst_n = 1'b1;
	end

endmodule

// File: hw/arcade_io_top.sv
// Memory port is a write-only Wishbone classic master with full 16-bit words
`timescale 1ns/1ns

module arcade_io_top import arcade_io_pkg::*; (
	input  logic      MS_CLK,
	input  logic      arst_n,
	input  joy_word_t joystick_0,
	input  joy_word_t joystick_1,
	input  logic      osd_status,
	input  logic      pause_in_osd,
	input  logic      ioctl_wr,
	input  dl_index_t ioctl_index,
	input  dl_addr_t  ioctl_addr,
	input  byte_t     ioctl_dout,
	output logic      ioctl_wait,
	output byte_t     player1,
	output byte_t     player2,
	output byte_t     dsw1,
	output byte_t     dsw2,
	output byte_t     game,
	output logic      service,
	output logic      pause_cpu,
	output logic      mem_cyc,
	output logic      mem_stb,
	output mem_adr_t  mem_adr,
	output rom_word_t mem_dat,
	input  logic      mem_ack
);

	joy_word_t [NUM_PLAYERS-1:0] joy_bus;

	player_if   pl [NUM_PLAYERS] ();
	rom_byte_if rb ();

	// Player 0 in the low slot
	assign joy_bus = {joystick_1, joystick_0};

	//////////////////////////////////////////////////
	// Download path
	//////////////////////////////////////////////////
	host_download u_host_download (
		.MS_CLK      (MS_CLK),
		.arst_n      (arst_n),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.ioctl_wait  (ioctl_wait),
		.dsw1        (dsw1),
		.dsw2        (dsw2),
		.game        (game),
		.rb          (rb)
	);

	rom_loader u_rom_loader (
		.MS_CLK  (MS_CLK),
		.arst_n  (arst_n),
		.rb      (rb),
		.mem_cyc (mem_cyc),
		.mem_stb (mem_stb),
		.mem_adr (mem_adr),
		.mem_dat (mem_dat),
		.mem_ack (mem_ack)
	);

	//////////////////////////////////////////////////
	// Player inputs
	//////////////////////////////////////////////////
	for (genvar i = 0; i < NUM_PLAYERS; i++) begin : g_player
		player_port u_player_port (
			.MS_CLK (MS_CLK),
			.arst_n (arst_n),
			.joy    (joy_bus[i]),
			.pl     (pl[i])
		);
	end

	cabinet_inputs u_cabinet_inputs (
		.MS_CLK       (MS_CLK),
		.arst_n       (arst_n),
		.p0           (pl[0]),
		.p1           (pl[1]),
		.osd_status   (osd_status),
		.pause_in_osd (pause_in_osd),
		.player1      (player1),
		.player2      (player2),
		.service      (service),
		.pause_cpu    (pause_cpu)
	);

endmodule

// File: hw/cabinet_inputs.sv
// Cabinet bytes are active low and simultaneous pause presses toggle the latch only once
`timescale 1ns/1ns

module cabinet_inputs (
	input  logic       MS_CLK,
	input  logic       arst_n,
	player_if.snk      p0,
	player_if.snk      p1,
	input  logic       osd_status,
	input  logic       pause_in_osd,
	output logic [7:0] player1,
	output logic [7:0] player2,
	output logic       service,
	output logic       pause_cpu
);

	logic latch;
	logic latch_nxt;
	logic menu_pause;

	// Either player's press flips the latch
	assign latch_nxt  = latch ^ (p0.pause_press | p1.pause_press);
	// Menu pause only while OSD is open
	assign menu_pause = pause_in_osd & osd_status;

	//////////////////////////////////////////////////
	// Cabinet bytes and pause
	//////////////////////////////////////////////////
	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			player1   <= '1;
			player2   <= '1;
			service   <= 1'b1;
			latch     <= 1'b0;
			pause_cpu <= 1'b0;
		end else begin
			// Start buttons cross over with the other side's alt start
			player1   <= {p1.start & p0.alt_start, p0.start & p1.alt_start,
				p0.sw2, p0.sw1, p0.down, p0.up, p0.left, p0.right};
			player2   <= {p1.coin, p0.coin,
				p1.sw2, p1.sw1, p1.down, p1.up, p1.left, p1.right};
			service   <= p0.service & p1.service;
			latch     <= latch_nxt;
			pause_cpu <= latch_nxt | menu_pause;
		end
	end

	// Edge detectors upstream give single cycle presses
	assert property (@(posedge MS_CLK) disable iff (!arst_n) p0.pause_press |=> !p0.pause_press);
	assert property (@(posedge MS_CLK) disable iff (!arst_n) p1.pause_press |=> !p1.pause_press);

endmodule

// File: hw/player_port.sv
// Controls lag the host word by one cycle and pause_press lags the pause bit by two
`timescale 1ns/1ns

module player_port import arcade_io_pkg::*; (
	input  logic      MS_CLK,
	input  logic      arst_n,
	input  joy_word_t joy,
	player_if.src     pl
);

	joy_word_t joy_q;
	logic      pause_d;

	// Host word sample, cleared word reads as released
	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			joy_q <= '0;
		end else begin
			joy_q <= joy;
		end
	end

	// Cabinet side is active low
	assign pl.right     = ~joy_q[JOY_RIGHT];
	assign pl.left      = ~joy_q[JOY_LEFT];
	assign pl.down      = ~joy_q[JOY_DOWN];
	assign pl.up        = ~joy_q[JOY_UP];
	assign pl.sw1       = ~joy_q[JOY_SW1];
	assign pl.sw2       = ~joy_q[JOY_SW2];
	assign pl.start     = ~joy_q[JOY_START];
	assign pl.coin      = ~joy_q[JOY_COIN];
	assign pl.service   = ~joy_q[JOY_SERVICE];
	assign pl.alt_start = ~joy_q[JOY_ALT_START];

	// Rising edge of pause bit
	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			pause_d        <= 1'b0;
			pl.pause_press <= 1'b0;
		end else begin
			pause_d        <= joy_q[JOY_PAUSE];
			pl.pause_press <= joy_q[JOY_PAUSE] & ~pause_d;
		end
	end

endmodule

// File: hw/rom_loader.sv
// Bytes arrive low then high and an orphan low byte is dropped when the next low byte lands
`timescale 1ns/1ns

module rom_loader import arcade_io_pkg::*; (
	input  logic       MS_CLK,
	input  logic       arst_n,
	rom_byte_if.loader rb,
	output logic       mem_cyc,
	output logic       mem_stb,
	output mem_adr_t   mem_adr,
	output rom_word_t  mem_dat,
	input  logic       mem_ack
);

	rom_state_t state;
	byte_t      lo_q;
	logic       hi_byte;
	logic       launch;

	// Odd address carries the upper half
	assign hi_byte = rb.addr[0];
	// Word complete, open a bus cycle
	assign launch  = rb.wr && hi_byte && (state == LOAD_HIGH);

	// Busy for the whole Wishbone cycle
	assign rb.wait_req = (state == LOAD_WRITE);

	//////////////////////////////////////////////////
	// Pairing FSM and bus control
	//////////////////////////////////////////////////
	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			state   <= LOAD_LOW;
			mem_cyc <= 1'b0;
			mem_stb <= 1'b0;
		end else begin
			unique case (state)
				LOAD_LOW: begin
					if (rb.wr && !hi_byte) begin
						state <= LOAD_HIGH;
					end
				end
				// Another low byte just replaces the held one
				LOAD_HIGH: begin
					if (launch) begin
						state   <= LOAD_WRITE;
						mem_cyc <= 1'b1;
						mem_stb <= 1'b1;
					end
				end
				LOAD_WRITE: begin
					if (mem_ack) begin
						state   <= LOAD_LOW;
						mem_cyc <= 1'b0;
						mem_stb <= 1'b0;
					end
				end
				default: state <= LOAD_LOW;
			endcase
		end
	end

	// Byte and word payload
	always_ff @(posedge MS_CLK) begin
		if (rb.wr && !hi_byte && (state != LOAD_WRITE)) begin
			lo_q <= rb.data;
		end
		if (launch) begin
			mem_adr <= rb.addr[DL_ADDR_W-1:1];
			mem_dat <= {rb.data, lo_q};
		end
	end

	// Request held steady until ack
	assert property (@(posedge MS_CLK) disable iff (!arst_n)
		mem_cyc && !mem_ack |=> mem_cyc && $stable(mem_adr) && $stable(mem_dat));
	assert property (@(posedge MS_CLK) disable iff (!arst_n) mem_stb |-> mem_cyc);

endmodule

// File: hw/host_download.sv
// Host must leave two idle cycles after each write before ioctl_wait is trusted
`timescale 1ns/1ns

module host_download import arcade_io_pkg::*; (
	input  logic      MS_CLK,
	input  logic      arst_n,
	input  logic      ioctl_wr,
	input  dl_index_t ioctl_index,
	input  dl_addr_t  ioctl_addr,
	input  byte_t     ioctl_dout,
	output logic      ioctl_wait,
	output byte_t     dsw1,
	output byte_t     dsw2,
	output byte_t     game,
	rom_byte_if.host  rb
);

	logic rom_hit;
	logic dip_hit;
	logic game_hit;

	// Write decode by stream index
	assign rom_hit  = ioctl_wr && (ioctl_index == DL_INDEX_ROM);
	// DIP banks 0 and 1 only
	assign dip_hit  = ioctl_wr && (ioctl_index == DL_INDEX_DIP)
		&& (ioctl_addr[DL_ADDR_W-1:1] == '0);
	assign game_hit = ioctl_wr && (ioctl_index == DL_INDEX_GAME) && (ioctl_addr == '0);

	always_ff @(posedge MS_CLK or negedge arst_n) begin
		if (!arst_n) begin
			dsw1  <= '0;
			dsw2  <= '0;
			game  <= '0;
			rb.wr <= 1'b0;
		end else begin
			rb.wr <= rom_hit;
			if (dip_hit && !ioctl_addr[0]) begin
				dsw1 <= ioctl_dout;
			end
			if (dip_hit && ioctl_addr[0]) begin
				dsw2 <= ioctl_dout;
			end
			if (game_hit) begin
				game <= ioctl_dout;
			end
		end
	end

	// ROM byte payload
	always_ff @(posedge MS_CLK) begin
		if (rom_hit) begin
			rb.addr <= ioctl_addr;
			rb.data <= ioctl_dout;
		end
	end

	// Loader back-pressure straight to host
	assign ioctl_wait = rb.wait_req;

	// Host spacing keeps bytes out of an open memory cycle
	assert property (@(posedge MS_CLK) disable iff (!arst_n) rb.wait_req |-> !rb.wr);

endmodule

// File: hw/arcade_io_ifs.sv
// Player controls are active low except pause_press and a ROM byte is taken whenever wr is high
`timescale 1ns/1ns

//////////////////////////////////////////////////
// One player's mapped cabinet controls
//////////////////////////////////////////////////
interface player_if;
	logic up;
	logic down;
	logic left;
	logic right;
	logic sw1;
	logic sw2;
	logic start;
	logic coin;
	logic service;
	logic alt_start;
	// Single cycle pulse per pause press
	logic pause_press;

	modport src (output up, down, left, right, sw1, sw2, start, coin, service, alt_start,
		pause_press);
	modport snk (input up, down, left, right, sw1, sw2, start, coin, service, alt_start,
		pause_press);
endinterface

//////////////////////////////////////////////////
// ROM byte stream from download decoder to loader
//////////////////////////////////////////////////
interface rom_byte_if import arcade_io_pkg::*; ();
	logic     wr;
	dl_addr_t addr;
	byte_t    data;
	// Loader busy with a memory cycle
	logic     wait_req;

	modport host   (output wr, addr, data, input wait_req);
	modport loader (input wr, addr, data, output wait_req);
endinterface

// File: hw/arcade_io_pkg.sv
// Only DIP banks 0 and 1 are kept and ROM words are always written in full
package arcade_io_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int BYTE_W    = 8;
	localparam int JOY_W     = 16;
	localparam int DL_ADDR_W = 25;
	localparam int WORD_W    = 16;
	// Word address drops the byte lane bit
	localparam int MEM_ADR_W = DL_ADDR_W - 1;

	typedef logic [BYTE_W-1:0]    byte_t;
	typedef logic [JOY_W-1:0]     joy_word_t;
	typedef logic [DL_ADDR_W-1:0] dl_addr_t;
	typedef logic [BYTE_W-1:0]    dl_index_t;
	typedef logic [WORD_W-1:0]    rom_word_t;
	typedef logic [MEM_ADR_W-1:0] mem_adr_t;

	//////////////////////////////////////////////////
	// Download stream indexes
	//////////////////////////////////////////////////
	localparam dl_index_t DL_INDEX_ROM  = 8'd0;
	localparam dl_index_t DL_INDEX_GAME = 8'd1;
	localparam dl_index_t DL_INDEX_DIP  = 8'd254;

	localparam int NUM_PLAYERS = 2;

	//////////////////////////////////////////////////
	// Host joystick word bit positions
	//////////////////////////////////////////////////
	localparam int JOY_RIGHT     = 0;
	localparam int JOY_LEFT      = 1;
	localparam int JOY_DOWN      = 2;
	localparam int JOY_UP        = 3;
	localparam int JOY_SW1       = 4;
	localparam int JOY_SW2       = 5;
	localparam int JOY_START     = 6;
	localparam int JOY_COIN      = 7;
	localparam int JOY_SERVICE   = 8;
	// Pause is the only active-high control
	localparam int JOY_PAUSE     = 9;
	localparam int JOY_ALT_START = 10;

	// ROM byte pairing FSM
	typedef enum logic [1:0] {LOAD_LOW, LOAD_HIGH, LOAD_WRITE} rom_state_t;

endpackage
